/* convSubsystem.f */
+incdir+hdl
hdl/imgTypes_pkg.sv
hdl/busTypes_pkg.sv
hdl/frameSequencer.sv
hdl/smoothPipe.sv
hdl/hostPort.sv
hdl/memArbiter.sv
hdl/frameRam.sv
hdl/convSubsystem.sv
tb/convSubsystem_tb.sv

/* hdl/busTypes_pkg.sv */
`include "convSubsystem_config.svh"

package busTypes_pkg;

    typedef struct packed {
        logic [`WB_DAT_W-`PIX_W-1:0] pad;
        imgTypes_pkg::pixel_t        pix;
    } pixelView_t;

    // start on write, busy on read
    typedef struct packed {
        logic                        startBusy;
        logic                        done;
        logic [7:0]                  passCount;
        logic [`WB_DAT_W-`ADDR_W-11:0] pad;
        logic [`ADDR_W-1:0]          length;
    } ctrlView_t;

    typedef union packed {
        pixelView_t pixel;
        ctrlView_t  ctrl;
    } hostWord_u;

    typedef enum logic {
        HOST,
        ENGINE
    } memOwner_e;

endpackage

/* hdl/convSubsystem.sv */
`timescale 1ns/100ps
`include "convSubsystem_config.svh"

module convSubsystem (
    input  logic                 i_CLK,
    input  logic                 i_reset,
    input  logic                 i_wbCyc,
    input  logic                 i_wbStb,
    input  logic                 i_wbWe,
    input  logic [`WB_ADR_W-1:0] i_wbAdr,
    input  logic [`WB_DAT_W-1:0] i_wbDat,
    output logic [`WB_DAT_W-1:0] o_wbDat,
    output logic                 o_wbAck
);

    logic                    hostReq;
    logic                    hostWe;
    logic [`ADDR_W:0]        hostAddr;
    imgTypes_pkg::pixel_t    hostWdata;
    logic                    hostAck;
    logic                    start;
    logic [`ADDR_W-1:0]      length;
    logic                    busy;
    logic                    done;
    logic [7:0]              passCount;
    logic                    seqRdEn;
    logic [`ADDR_W-1:0]      seqRdAddr;
    logic [`ADDR_W-1:0]      seqWrAddr;
    logic [`ADDR_W-1:0]      rdAddrDly;
    logic                    pipeVld;
    logic                    pipeFirst;
    logic                    pipeWrEn;
    imgTypes_pkg::pixel_t    pipeData;
    logic                    ramRdEn;
    logic [`ADDR_W:0]        ramRdAddr;
    logic                    ramWrEn;
    logic [`ADDR_W:0]        ramWrAddr;
    imgTypes_pkg::pixel_t    ramWrData;
    imgTypes_pkg::pixel_t    ramRdData;

    hostPort hostPort_inst (
        .i_CLK(i_CLK), .i_reset(i_reset),
        .i_wbCyc(i_wbCyc), .i_wbStb(i_wbStb), .i_wbWe(i_wbWe),
        .i_wbAdr(i_wbAdr), .i_wbDat(i_wbDat),
        .i_memAck(hostAck), .i_memRdata(ramRdData),
        .i_busy(busy), .i_done(done), .i_passCount(passCount),
        .o_wbDat(o_wbDat), .o_wbAck(o_wbAck),
        .o_memReq(hostReq), .o_memWe(hostWe), .o_memAddr(hostAddr),
        .o_memWdata(hostWdata), .o_start(start), .o_length(length)
    );

    // engine reads the input bank and writes the output bank
    memArbiter memArbiter_inst (
        .i_CLK(i_CLK), .i_reset(i_reset), .i_busy(busy),
        .i_hostReq(hostReq), .i_hostWe(hostWe), .i_hostAddr(hostAddr),
        .i_hostWdata(hostWdata),
        .i_engRdEn(seqRdEn), .i_engRdAddr({1'b0, seqRdAddr}),
        .i_engWrEn(pipeWrEn), .i_engWrAddr({1'b1, seqWrAddr}),
        .i_engWrData(pipeData),
        .o_hostAck(hostAck), .o_ramRdEn(ramRdEn), .o_ramRdAddr(ramRdAddr),
        .o_ramWrEn(ramWrEn), .o_ramWrAddr(ramWrAddr), .o_ramWrData(ramWrData),
        .o_owner()
    );

    frameRam frameRam_inst (
        .i_CLK(i_CLK),
        .i_rdEn(ramRdEn), .i_rdAddr(ramRdAddr),
        .i_wrEn(ramWrEn), .i_wrAddr(ramWrAddr), .i_wrData(ramWrData),
        .o_rdData(ramRdData)
    );

    frameSequencer frameSequencer_inst (
        .i_CLK(i_CLK), .i_reset(i_reset),
        .i_start(start), .i_length(length),
        .o_rdEn(seqRdEn), .o_rdAddr(seqRdAddr), .o_wrAddr(seqWrAddr),
        .o_busy(busy), .o_done(done), .o_passCount(passCount)
    );

    // ram data lands one cycle after the engine read
    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            pipeVld <= 1'b0;
        end else begin
            pipeVld <= seqRdEn;
        end
    end

    always_ff @(posedge i_CLK) begin
        rdAddrDly <= seqRdAddr;
    end

    assign pipeFirst = pipeVld & (rdAddrDly == '0);

    smoothPipe smoothPipe_inst (
        .i_CLK(i_CLK), .i_reset(i_reset),
        .i_first(pipeFirst), .i_inVld(pipeVld), .i_pixel(ramRdData),
        .o_outVld(pipeWrEn), .o_result(pipeData)
    );

endmodule

/* hdl/convSubsystem_config.svh */
`ifndef CONV_SUBSYSTEM_CONFIG_SVH
`define CONV_SUBSYSTEM_CONFIG_SVH

`define PIX_W     8
`define ADDR_W    10
// bit 11 control, bit 10 bank, bits 9..0 index
`define WB_ADR_W  12
`define WB_DAT_W  32
// ram read stage plus two filter stages
`define PIPE_LAT  3

`endif

/* hdl/frameRam.sv */
`timescale 1ns/100ps
`include "convSubsystem_config.svh"

module frameRam (
    input  logic                 i_CLK,
    input  logic                 i_rdEn,
    input  logic [`ADDR_W:0]     i_rdAddr,
    input  logic                 i_wrEn,
    input  logic [`ADDR_W:0]     i_wrAddr,
    input  imgTypes_pkg::pixel_t i_wrData,
    output imgTypes_pkg::pixel_t o_rdData
);

    // input bank below, output bank above
    localparam int DEPTH = 2 << `ADDR_W;

    imgTypes_pkg::pixel_t mem [DEPTH];

    always_ff @(posedge i_CLK) begin
        if (i_wrEn) begin
            mem[i_wrAddr] <= i_wrData;
        end
        if (i_rdEn) begin
            o_rdData <= mem[i_rdAddr];
        end
    end

endmodule

/* hdl/frameSequencer.sv */
`timescale 1ns/100ps
`include "convSubsystem_config.svh"

module frameSequencer (
    input  logic               i_CLK,
    input  logic               i_reset,
    input  logic               i_start,
    input  logic [`ADDR_W-1:0] i_length,
    output logic               o_rdEn,
    output logic [`ADDR_W-1:0] o_rdAddr,
    output logic [`ADDR_W-1:0] o_wrAddr,
    output logic               o_busy,
    output logic               o_done,
    output logic [7:0]         o_passCount
);

    localparam int FLUSH_W = $clog2(`PIPE_LAT + 1);

    imgTypes_pkg::seqState_e state;
    logic [`ADDR_W-1:0]      lastAddr;
    logic [FLUSH_W-1:0]      flushCnt;
    logic [`ADDR_W-1:0]      addrPipe [`PIPE_LAT];

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            state       <= imgTypes_pkg::IDLE;
            o_rdAddr    <= '0;
            lastAddr    <= '0;
            flushCnt    <= '0;
            o_done      <= 1'b0;
            o_passCount <= '0;
        end else begin
            case (state)
                imgTypes_pkg::IDLE, imgTypes_pkg::DONE: begin
                    // a new pass also clears done
                    if (i_start) begin
                        o_rdAddr <= '0;
                        lastAddr <= i_length - 1'b1;
                        flushCnt <= '0;
                        o_done   <= 1'b0;
                        if (i_length == '0) begin
                            state <= imgTypes_pkg::FLUSH;
                        end else begin
                            state <= imgTypes_pkg::PROCESS;
                        end
                    end
                end
                imgTypes_pkg::PROCESS: begin
                    if (o_rdAddr == lastAddr) begin
                        state <= imgTypes_pkg::FLUSH;
                    end else begin
                        o_rdAddr <= o_rdAddr + 1'b1;
                    end
                end
                imgTypes_pkg::FLUSH: begin
                    // write side catches up, plus one guard cycle
                    if (flushCnt == FLUSH_W'(`PIPE_LAT)) begin
                        state       <= imgTypes_pkg::DONE;
                        o_done      <= 1'b1;
                        o_passCount <= o_passCount + 1'b1;
                    end else begin
                        flushCnt <= flushCnt + 1'b1;
                    end
                end
                default: begin
                    state <= imgTypes_pkg::IDLE;
                end
            endcase
        end
    end

    // lagged copy of the read address
    always_ff @(posedge i_CLK) begin
        addrPipe[0] <= o_rdAddr;
        for (int k = 1; k < `PIPE_LAT; k++) begin
            addrPipe[k] <= addrPipe[k-1];
        end
    end

    assign o_rdEn   = (state == imgTypes_pkg::PROCESS);
    assign o_busy   = (state == imgTypes_pkg::PROCESS) || (state == imgTypes_pkg::FLUSH);
    assign o_wrAddr = addrPipe[`PIPE_LAT-1];

endmodule

/* hdl/hostPort.sv */
`timescale 1ns/100ps
`include "convSubsystem_config.svh"

module hostPort (
    input  logic                 i_CLK,
    input  logic                 i_reset,
    input  logic                 i_wbCyc,
    input  logic                 i_wbStb,
    input  logic                 i_wbWe,
    input  logic [`WB_ADR_W-1:0] i_wbAdr,
    input  logic [`WB_DAT_W-1:0] i_wbDat,
    input  logic                 i_memAck,
    input  imgTypes_pkg::pixel_t i_memRdata,
    input  logic                 i_busy,
    input  logic                 i_done,
    input  logic [7:0]           i_passCount,
    output logic [`WB_DAT_W-1:0] o_wbDat,
    output logic                 o_wbAck,
    output logic                 o_memReq,
    output logic                 o_memWe,
    output logic [`ADDR_W:0]     o_memAddr,
    output imgTypes_pkg::pixel_t o_memWdata,
    output logic                 o_start,
    output logic [`ADDR_W-1:0]   o_length
);

    busTypes_pkg::hostWord_u wbIn;
    busTypes_pkg::hostWord_u wbOut;
    logic                    req;
    logic                    isCtrl;
    logic                    ctrlAck;

    assign wbIn   = i_wbDat;
    assign req    = i_wbCyc & i_wbStb;
    assign isCtrl = i_wbAdr[`WB_ADR_W-1];

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            ctrlAck  <= 1'b0;
            o_start  <= 1'b0;
            o_memReq <= 1'b0;
            o_length <= '0;
        end else begin
            ctrlAck <= 1'b0;
            o_start <= 1'b0;
            if (req && isCtrl && !ctrlAck) begin
                ctrlAck <= 1'b1;
                if (i_wbWe && wbIn.ctrl.startBusy) begin
                    o_start  <= 1'b1;
                    o_length <= wbIn.ctrl.length;
                end
            end
            // pixel access held until the arbiter completes it
            if (o_memReq) begin
                if (i_memAck) begin
                    o_memReq <= 1'b0;
                end
            end else if (req && !isCtrl) begin
                o_memReq <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_CLK) begin
        if (!o_memReq) begin
            o_memWe    <= i_wbWe;
            o_memAddr  <= i_wbAdr[`ADDR_W:0];
            o_memWdata <= wbIn.pixel.pix;
        end
    end

    always_comb begin
        wbOut = '0;
        if (isCtrl) begin
            wbOut.ctrl.startBusy = i_busy;
            wbOut.ctrl.done      = i_done;
            wbOut.ctrl.passCount = i_passCount;
            wbOut.ctrl.length    = o_length;
        end else begin
            wbOut.pixel.pix = i_memRdata;
        end
    end

    assign o_wbDat = wbOut;
    assign o_wbAck = ctrlAck | i_memAck;

endmodule

/* hdl/imgTypes_pkg.sv */
`include "convSubsystem_config.svh"

package imgTypes_pkg;

    typedef logic [`PIX_W-1:0] pixel_t;

    // room for 4x a full scale pixel
    typedef logic [`PIX_W+1:0] acc_t;

    // current, previous, before previous
    localparam acc_t W0 = acc_t'(1);
    localparam acc_t W1 = acc_t'(2);
    localparam acc_t W2 = acc_t'(1);

    typedef enum logic [1:0] {
        IDLE,
        PROCESS,
        FLUSH,
        DONE
    } seqState_e;

endpackage

/* hdl/memArbiter.sv */
`timescale 1ns/100ps
`include "convSubsystem_config.svh"

module memArbiter (
    input  logic                    i_CLK,
    input  logic                    i_reset,
    input  logic                    i_busy,
    input  logic                    i_hostReq,
    input  logic                    i_hostWe,
    input  logic [`ADDR_W:0]        i_hostAddr,
    input  imgTypes_pkg::pixel_t    i_hostWdata,
    input  logic                    i_engRdEn,
    input  logic [`ADDR_W:0]        i_engRdAddr,
    input  logic                    i_engWrEn,
    input  logic [`ADDR_W:0]        i_engWrAddr,
    input  imgTypes_pkg::pixel_t    i_engWrData,
    output logic                    o_hostAck,
    output logic                    o_ramRdEn,
    output logic [`ADDR_W:0]        o_ramRdAddr,
    output logic                    o_ramWrEn,
    output logic [`ADDR_W:0]        o_ramWrAddr,
    output imgTypes_pkg::pixel_t    o_ramWrData,
    output busTypes_pkg::memOwner_e o_owner
);

    logic readWait;
    logic hostIssue;

    // engine owns both ports for the whole pass
    assign o_owner = i_busy ? busTypes_pkg::ENGINE : busTypes_pkg::HOST;

    assign hostIssue = i_hostReq & (o_owner == busTypes_pkg::HOST) & ~readWait & ~o_hostAck;

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            readWait  <= 1'b0;
            o_hostAck <= 1'b0;
        end else begin
            // reads take one extra cycle for ram data
            readWait  <= hostIssue & ~i_hostWe;
            o_hostAck <= (hostIssue & i_hostWe) | readWait;
        end
    end

    always_comb begin
        if (o_owner == busTypes_pkg::ENGINE) begin
            o_ramRdEn   = i_engRdEn;
            o_ramRdAddr = i_engRdAddr;
            o_ramWrEn   = i_engWrEn;
            o_ramWrAddr = i_engWrAddr;
            o_ramWrData = i_engWrData;
        end else begin
            o_ramRdEn   = hostIssue & ~i_hostWe;
            o_ramRdAddr = i_hostAddr;
            o_ramWrEn   = hostIssue & i_hostWe;
            o_ramWrAddr = i_hostAddr;
            o_ramWrData = i_hostWdata;
        end
    end

endmodule

/* hdl/smoothPipe.sv */
`timescale 1ns/100ps
`include "convSubsystem_config.svh"

module smoothPipe (
    input  logic                 i_CLK,
    input  logic                 i_reset,
    input  logic                 i_first,
    input  logic                 i_inVld,
    input  imgTypes_pkg::pixel_t i_pixel,
    output logic                 o_outVld,
    output imgTypes_pkg::pixel_t o_result
);

    imgTypes_pkg::pixel_t prev1;
    imgTypes_pkg::pixel_t prev2;
    imgTypes_pkg::pixel_t tap1;
    imgTypes_pkg::pixel_t tap2;
    imgTypes_pkg::acc_t   sum;
    logic                 sumVld;

    // samples before index 0 count as zero
    assign tap1 = i_first ? '0 : prev1;
    assign tap2 = i_first ? '0 : prev2;

    always_ff @(posedge i_CLK) begin
        if (i_inVld) begin
            prev1 <= i_pixel;
            prev2 <= tap1;
        end
        sum      <= imgTypes_pkg::W0 * i_pixel + imgTypes_pkg::W1 * tap1
                    + imgTypes_pkg::W2 * tap2;
        // divide by the kernel gain of 4
        o_result <= sum[`PIX_W+1:2];
    end

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            sumVld   <= 1'b0;
            o_outVld <= 1'b0;
        end else begin
            sumVld   <= i_inVld;
            o_outVld <= sumVld;
        end
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, exit status follows the simulation result
verilator --binary --timescale 1ns/100ps -Wno-fatal --top-module convSubsystem_tb \
    -f convSubsystem.f -o simv && ./obj_dir/simv || exit 1

/* tb/convSubsystem_tb.sv */
`timescale 1ns/100ps

module convSubsystem_tb;

    localparam int          ACK_LIMIT = 64;
    localparam int          SEED      = 70775;
    localparam logic [11:0] CTRL_ADR  = 12'h800;
    localparam logic [31:0] START_BIT = 32'h8000_0000;

    logic        i_CLK;
    logic        i_reset;
    logic        i_wbCyc;
    logic        i_wbStb;
    logic        i_wbWe;
    logic [11:0] i_wbAdr;
    logic [31:0] i_wbDat;
    logic [31:0] o_wbDat;
    logic        o_wbAck;

    byte         cmdList  [$];
    logic [31:0] argAList [$];
    logic [31:0] argBList [$];
    int          cycleCount = 0;
    int          cycleLimit = 0;

    convSubsystem convSubsystem_inst (
        .i_CLK(i_CLK), .i_reset(i_reset),
        .i_wbCyc(i_wbCyc), .i_wbStb(i_wbStb), .i_wbWe(i_wbWe),
        .i_wbAdr(i_wbAdr), .i_wbDat(i_wbDat),
        .o_wbDat(o_wbDat), .o_wbAck(o_wbAck)
    );

    initial begin
        i_CLK = 1'b0;
        forever #20 i_CLK = ~i_CLK;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            abortRun($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // one classic cycle that starts and ends on a falling edge
    task automatic busAccess(input logic we, input logic [11:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int waitCycles;
        waitCycles = 0;
        i_wbCyc = 1'b1;
        i_wbStb = 1'b1;
        i_wbWe  = we;
        i_wbAdr = adr;
        i_wbDat = wdat;
        @(negedge i_CLK);
        while (!o_wbAck) begin
            if (waitCycles >= ACK_LIMIT) begin
                abortRun($sformatf("no acknowledge from the DUT for address %h", adr));
            end else begin
                waitCycles++;
                @(negedge i_CLK);
            end
        end
        rdat    = o_wbDat;
        i_wbCyc = 1'b0;
        i_wbStb = 1'b0;
        i_wbWe  = 1'b0;
    endtask

    task automatic loadTests(output int lineCount, output int maxLength);
        int          fd;
        int          ch;
        int          got;
        int          need;
        byte         cmd;
        logic [31:0] a;
        logic [31:0] b;
        lineCount = 0;
        maxLength = 0;
        fd = $fopen("tb/conv_tests.txt", "r");
        if (fd == 0) begin
            abortRun("could not open the test file tb/conv_tests.txt");
        end else begin
            while ($fscanf(fd, " %c", cmd) == 1) begin
                lineCount++;
                a = '0;
                b = '0;
                if (cmd == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    if (cmd == "W" || cmd == "R") begin
                        need = 2;
                        got  = $fscanf(fd, "%h %h", a, b);
                    end else begin
                        need = 1;
                        got  = $fscanf(fd, "%h", a);
                    end
                    if (got != need || !(cmd inside {"W", "R", "S", "P"})) begin
                        abortRun($sformatf("bad command on line %0d of the test file",
                                           lineCount));
                    end else begin
                        if (cmd == "S" && int'(a) > maxLength) begin
                            maxLength = int'(a);
                        end
                        cmdList.push_back(cmd);
                        argAList.push_back(a);
                        argBList.push_back(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // status word carries busy in bit 31, done in 30 and the pass count in 29..22
    task automatic pollDone(input logic [31:0] expCount);
        logic [31:0] rdat;
        rdat = '0;
        while (!rdat[30]) begin
            busAccess(1'b0, CTRL_ADR, 32'h0, rdat);
        end
        checkValue("busy", 32'h0, {31'h0, rdat[31]});
        checkValue("passCount", expCount, {24'h0, rdat[29:22]});
    endtask

    task automatic runTests;
        logic [31:0] rdat;
        int          idle;
        for (int n = 0; n < cmdList.size(); n++) begin
            case (cmdList[n])
                "W": busAccess(1'b1, argAList[n][11:0], argBList[n], rdat);
                "R": begin
                    busAccess(1'b0, argAList[n][11:0], 32'h0, rdat);
                    checkValue($sformatf("o_wbDat[%h]", argAList[n][11:0]), argBList[n], rdat);
                end
                "S": busAccess(1'b1, CTRL_ADR, START_BIT | argAList[n], rdat);
                default: pollDone(argAList[n]);
            endcase
            idle = int'($urandom % 4);
            repeat (idle) @(negedge i_CLK);
        end
    endtask

    always @(posedge i_CLK) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            abortRun($sformatf("timeout, run still going after %0d cycles", cycleCount));
        end
    end

    initial begin
        int lineCount;
        int maxLength;
        i_reset  = 1'b1;
        i_wbCyc  = 1'b0;
        i_wbStb  = 1'b0;
        i_wbWe   = 1'b0;
        i_wbAdr  = '0;
        i_wbDat  = '0;
        void'($urandom(SEED));
        loadTests(lineCount, maxLength);
        cycleLimit = 200 * lineCount + maxLength;
        repeat (10) @(negedge i_CLK);
        i_reset = 1'b0;
        checkValue("o_wbAck", 32'h0, {31'h0, o_wbAck});
        runTests();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* tb/conv_tests.txt */
# W addr data | R addr expected | S length | P pass count, all hex
# addr 800 control, 000-3FF input bank, 400-7FF output bank
R 800 00000000
W 000 10
W 001 20
W 002 30
W 003 40
W 004 FF
W 005 FF
W 006 FF
W 007 00
W 008 80
W 009 01
W 00A FE
W 00B 7F
W 00C 33
W 00D C8
W 00E FF
W 00F 05
R 002 30
R 004 FF
S 010
R 800 80000010
R 40F B2
R 800 40400010
P 01
R 400 04
R 401 10
R 402 20
R 403 30
R 404 6B
R 405 CF
R 406 FF
R 407 BF
R 408 5F
R 409 40
R 40A 60
R 40B 9F
R 40C 8B
R 40D 6B
R 40E B0
W 002 00
W 00A 00
R 00A 00
S 008
P 02
R 800 40800008
R 402 14
R 403 18
R 404 5F
R 407 BF
R 40A 60
R 40B 9F
R 40C 8B
